//--- cpuPkg.sv
`default_nettype none

package cpuPkg;

        // ~~~~~~~~~~~~~~~~~~~~
        // widths
        // ~~~~~~~~~~~~~~~~~~~~
        localparam int dataWidth  = 16;
        localparam int regIdWidth = 4;
        localparam int numRegs    = 16;

        // ~~~~~~~~~~~~~~~~~~~~
        // vector types
        // ~~~~~~~~~~~~~~~~~~~~
        typedef logic [dataWidth-1:0]  word_t;
        typedef logic [regIdWidth-1:0] regId_t;
        typedef logic [numRegs-1:0]    wordline_t;  // one bit per register

        // ~~~~~~~~~~~~~~~~~~~~
        // opcodes
        // ~~~~~~~~~~~~~~~~~~~~
        typedef enum logic [2:0] {
                OP_ADD,  // saturating
                OP_SUB,  // saturating
                OP_XOR,
                OP_SLL,
                OP_SRA,
                OP_ROR,
                OP_LLB,  // load low byte
                OP_LHB   // load high byte
        } aluOp_t;

endpackage

`default_nettype wire

//--- register.sv
`default_nettype none

module register (
        input  logic          clk,
        input  logic          rstN,
        input  cpuPkg::word_t d,
        input  logic          writeEnable,
        input  logic          readEnable1,
        input  logic          readEnable2,
        output cpuPkg::word_t bitline1,
        output cpuPkg::word_t bitline2
);
        import cpuPkg::*;

        word_t storedWord;

        always_ff @(posedge clk) begin
                if (!rstN) begin
                        storedWord <= '0;
                end else if (writeEnable) begin
                        storedWord <= d;
                end
        end

        // unselected register drives zero so the parent can OR the bitlines
        assign bitline1 = readEnable1 ? storedWord : '0;
        assign bitline2 = readEnable2 ? storedWord : '0;

endmodule

`default_nettype wire

//--- regFile.sv
`default_nettype none

module regFile (
        input  logic           clk,
        input  logic           rstN,
        input  cpuPkg::regId_t srcReg1,
        input  cpuPkg::regId_t srcReg2,
        input  cpuPkg::regId_t dstReg,
        input  logic           writeReg,
        input  cpuPkg::word_t  dstData,
        output cpuPkg::word_t  srcData1,
        output cpuPkg::word_t  srcData2
);
        import cpuPkg::*;

        wordline_t readWordline1;
        wordline_t readWordline2;
        wordline_t writeWordline;
        word_t     bitline1 [numRegs];
        word_t     bitline2 [numRegs];

        // ~~~~~~~~~~~~~~~~~~~~
        // wordline decode
        // ~~~~~~~~~~~~~~~~~~~~
        assign readWordline1 = wordline_t'(1) << srcReg1;
        assign readWordline2 = wordline_t'(1) << srcReg2;
        assign writeWordline = writeReg ? (wordline_t'(1) << dstReg) : '0;

        // ~~~~~~~~~~~~~~~~~~~~
        // register array
        // ~~~~~~~~~~~~~~~~~~~~
        for (genvar i = 0; i < numRegs; i++) begin : gReg
                if (i == 0) begin : gZero
                        // r0 never loads, so it reads zero after reset
                        register regZero (
                                .clk         (clk),
                                .rstN        (rstN),
                                .d           (word_t'(0)),
                                .writeEnable (1'b0),
                                .readEnable1 (readWordline1[i]),
                                .readEnable2 (readWordline2[i]),
                                .bitline1    (bitline1[i]),
                                .bitline2    (bitline2[i])
                        );
                end else begin : gData
                        register regData (
                                .clk         (clk),
                                .rstN        (rstN),
                                .d           (dstData),
                                .writeEnable (writeWordline[i]),
                                .readEnable1 (readWordline1[i]),
                                .readEnable2 (readWordline2[i]),
                                .bitline1    (bitline1[i]),
                                .bitline2    (bitline2[i])
                        );
                end
        end

        // wired-OR of the bitlines, one per read port
        always_comb begin
                srcData1 = '0;
                srcData2 = '0;
                for (int i = 0; i < numRegs; i++) begin
                        srcData1 = srcData1 | bitline1[i];
                        srcData2 = srcData2 | bitline2[i];
                end
        end

        // ~~~~~~~~~~~~~~~~~~~~
        // checks
        // ~~~~~~~~~~~~~~~~~~~~
        writeOneHot: assert property (@(posedge clk) $onehot0(writeWordline));

        // holds through any write aimed at r0
        zeroReadsZero1: assert property (@(posedge clk) disable iff (!rstN)
                (srcReg1 == '0) |-> (srcData1 == '0));
        zeroReadsZero2: assert property (@(posedge clk) disable iff (!rstN)
                (srcReg2 == '0) |-> (srcData2 == '0));

endmodule

`default_nettype wire

//--- alu.sv
`default_nettype none

module alu (
        input  cpuPkg::aluOp_t op,
        input  cpuPkg::word_t  a,
        input  cpuPkg::word_t  b,
        input  logic [3:0]     shamt,
        input  logic [7:0]     imm8,
        output cpuPkg::word_t  y,
        output logic           ovf
);
        import cpuPkg::*;

        word_t                  sum;
        word_t                  diff;
        logic                   addOvf;
        logic                   subOvf;
        word_t                  satValue;
        logic [2*dataWidth-1:0] rotWide;

        // ~~~~~~~~~~~~~~~~~~~~
        // arithmetic
        // ~~~~~~~~~~~~~~~~~~~~
        assign sum  = a + b;
        assign diff = a - b;

        // same-sign operands, different-sign sum
        assign addOvf = (a[dataWidth-1] == b[dataWidth-1]) &&
                        (sum[dataWidth-1] != a[dataWidth-1]);
        // opposite-sign operands, result sign flips from a
        assign subOvf = (a[dataWidth-1] != b[dataWidth-1]) &&
                        (diff[dataWidth-1] != a[dataWidth-1]);

        // clamp toward the sign of a
        assign satValue = a[dataWidth-1] ? {1'b1, {(dataWidth-1){1'b0}}}
                                         : {1'b0, {(dataWidth-1){1'b1}}};

        assign rotWide = {a, a} >> shamt;  // low half is a rotated right

        // ~~~~~~~~~~~~~~~~~~~~
        // result select
        // ~~~~~~~~~~~~~~~~~~~~
        always_comb begin
                y   = '0;
                ovf = 1'b0;
                case (op)
                        OP_ADD: begin
                                ovf = addOvf;
                                y   = addOvf ? satValue : sum;
                        end
                        OP_SUB: begin
                                ovf = subOvf;
                                y   = subOvf ? satValue : diff;
                        end
                        OP_XOR: y = a ^ b;
                        OP_SLL: y = a << shamt;
                        OP_SRA: y = word_t'($signed(a) >>> shamt);
                        OP_ROR: y = rotWide[dataWidth-1:0];
                        OP_LLB: y = {a[dataWidth-1:8], imm8};
                        OP_LHB: y = {imm8, a[7:0]};
                        default: y = '0;
                endcase
        end

endmodule

`default_nettype wire

//--- flagReg.sv
`default_nettype none

module flagReg (
        input  logic           clk,
        input  logic           rstN,
        input  cpuPkg::aluOp_t op,
        input  cpuPkg::word_t  result,
        input  logic           ovf,
        output logic           zFlag,
        output logic           vFlag,
        output logic           nFlag
);
        import cpuPkg::*;

        logic isArith;
        logic isByteLoad;

        assign isArith    = (op == OP_ADD) || (op == OP_SUB);
        assign isByteLoad = (op == OP_LLB) || (op == OP_LHB);

        always_ff @(posedge clk) begin
                if (!rstN) begin
                        zFlag <= 1'b0;
                        vFlag <= 1'b0;
                        nFlag <= 1'b0;
                end else begin
                        if (!isByteLoad) begin
                                zFlag <= (result == '0);
                        end
                        if (isArith) begin  // v and n hold otherwise
                                vFlag <= ovf;
                                nFlag <= result[dataWidth-1];
                        end
                end
        end

        // alu must keep ovf quiet for logic, shift and load ops
        ovfOnlyArith: assert property (@(posedge clk) disable iff (!rstN)
                ovf |-> isArith);

endmodule

`default_nettype wire

//--- execCore.sv
`default_nettype none

module execCore (
        input  logic           clk,
        input  logic           rstN,
        input  cpuPkg::aluOp_t op,
        input  cpuPkg::regId_t dstReg,
        input  cpuPkg::regId_t srcReg1,
        input  cpuPkg::regId_t srcReg2,
        input  logic [3:0]     shamt,
        input  logic [7:0]     imm8,
        input  logic           writeReg,
        output cpuPkg::word_t  result,
        output logic           zFlag,
        output logic           vFlag,
        output logic           nFlag
);
        import cpuPkg::*;

        word_t srcData1;
        word_t srcData2;
        logic  ovf;

        regFile regs (
                .clk      (clk),
                .rstN     (rstN),
                .srcReg1  (srcReg1),
                .srcReg2  (srcReg2),
                .dstReg   (dstReg),
                .writeReg (writeReg),
                .dstData  (result),  // written back on the next edge
                .srcData1 (srcData1),
                .srcData2 (srcData2)
        );

        alu aluUnit (
                .op    (op),
                .a     (srcData1),
                .b     (srcData2),
                .shamt (shamt),
                .imm8  (imm8),
                .y     (result),
                .ovf   (ovf)
        );

        flagReg flags (
                .clk    (clk),
                .rstN   (rstN),
                .op     (op),
                .result (result),
                .ovf    (ovf),
                .zFlag  (zFlag),
                .vFlag  (vFlag),
                .nFlag  (nFlag)
        );

endmodule

`default_nettype wire

//--- execCoreTb.sv
`default_nettype none

module execCoreTb;
        import cpuPkg::*;

        localparam int period        = 8;
        localparam int resetCycles   = 8;
        localparam int numShifts     = 64;
        localparam int numRandom     = 2000;
        localparam int margin        = 200;
        localparam int plannedCycles = resetCycles + 4 * numRegs + 40 + numShifts + numRandom;

        logic        clk;
        logic        rstN;
        aluOp_t      op;
        regId_t      dstReg;
        regId_t      srcReg1;
        regId_t      srcReg2;
        logic [3:0]  shamt;
        logic [7:0]  imm8;
        logic        writeReg;
        word_t       result;
        logic        zFlag;
        logic        vFlag;
        logic        nFlag;

        word_t       shadowReg [numRegs];
        logic        shadowZ;
        logic        shadowV;
        logic        shadowN;
        word_t       expResult;
        logic        expOvf;
        logic [31:0] rngState = 32'hee0c_d76d;

        execCore UUT (
                .clk      (clk),
                .rstN     (rstN),
                .op       (op),
                .dstReg   (dstReg),
                .srcReg1  (srcReg1),
                .srcReg2  (srcReg2),
                .shamt    (shamt),
                .imm8     (imm8),
                .writeReg (writeReg),
                .result   (result),
                .zFlag    (zFlag),
                .vFlag    (vFlag),
                .nFlag    (nFlag)
        );

        initial begin
                clk = 1'b0;
                forever #(period / 2) clk = ~clk;
        end

        function automatic logic [31:0] nextRandom();
                logic [31:0] x;
                x = rngState;
                x = x ^ (x << 13);
                x = x ^ (x >> 17);
                x = x ^ (x << 5);
                rngState = x;
                return x;
        endfunction

        // ~~~~~~~~~~~~~~~~~~~~
        // reference model
        // ~~~~~~~~~~~~~~~~~~~~
        function automatic void modelAlu(input aluOp_t f, input word_t x, input word_t y,
                                         input logic [3:0] s, input logic [7:0] b8,
                                         output word_t val, output logic ovf);
                int sx;
                int sy;
                int full;
                sx   = {{16{x[15]}}, x};
                sy   = {{16{y[15]}}, y};
                full = 0;
                ovf  = 1'b0;
                case (f)
                        OP_ADD, OP_SUB: begin
                                full = (f == OP_ADD) ? sx + sy : sx - sy;
                                ovf  = (full > 32767) || (full < -32768);
                                if (full > 32767) val = 16'h7fff;
                                else if (full < -32768) val = 16'h8000;
                                else val = full[15:0];
                        end
                        OP_XOR: val = x ^ y;
                        OP_SLL: val = x << s;
                        OP_SRA: val = word_t'(sx >>> s);  // int is signed
                        OP_ROR: val = (x >> s) | (x << (5'd16 - {1'b0, s}));
                        OP_LLB: val = {x[15:8], b8};
                        OP_LHB: val = {b8, x[7:0]};
                        default: val = '0;
                endcase
        endfunction

        always_comb begin
                modelAlu(op, shadowReg[srcReg1], shadowReg[srcReg2], shamt, imm8,
                         expResult, expOvf);
        end

        always @(posedge clk) begin
                if (!rstN) begin
                        for (int i = 0; i < numRegs; i++) shadowReg[i] <= '0;
                        shadowZ <= 1'b0;
                        shadowV <= 1'b0;
                        shadowN <= 1'b0;
                end else begin
                        if (writeReg && dstReg != 4'd0) shadowReg[dstReg] <= expResult;
                        if (op != OP_LLB && op != OP_LHB) shadowZ <= (expResult == '0);
                        if (op == OP_ADD || op == OP_SUB) begin
                                shadowV <= expOvf;
                                shadowN <= expResult[15];
                        end
                end
        end

        task automatic abortRun();
                $display("Test FAILED");
                $fatal(1, "stopping at first failure");
        endtask

        task automatic reportMismatch(input string name, input word_t expected,
                                      input word_t actual);
                $display("[ERROR] time %0t %s expected %h actual %h", $time, name,
                         expected, actual);
                abortRun();
        endtask

        // ~~~~~~~~~~~~~~~~~~~~
        // checks
        // ~~~~~~~~~~~~~~~~~~~~
        resultMatch: assert property (@(negedge clk) disable iff (!rstN) result == expResult)
                else reportMismatch("result", expResult, result);
        zMatch: assert property (@(negedge clk) disable iff (!rstN) zFlag == shadowZ)
                else reportMismatch("zFlag", word_t'(shadowZ), word_t'(zFlag));
        vMatch: assert property (@(negedge clk) disable iff (!rstN) vFlag == shadowV)
                else reportMismatch("vFlag", word_t'(shadowV), word_t'(vFlag));
        nMatch: assert property (@(negedge clk) disable iff (!rstN) nFlag == shadowN)
                else reportMismatch("nFlag", word_t'(shadowN), word_t'(nFlag));
        zeroRead: assert property (@(negedge clk) disable iff (!rstN)
                (op == OP_XOR && srcReg1 == 4'd0 && srcReg2 == 4'd0) |-> result == '0)
                else reportMismatch("result", '0, result);

        task automatic issue(input aluOp_t f, input regId_t d, input regId_t s1,
                             input regId_t s2, input logic [3:0] sh, input logic [7:0] b8,
                             input logic we);
                @(posedge clk);
                op       <= f;
                dstReg   <= d;
                srcReg1  <= s1;
                srcReg2  <= s2;
                shamt    <= sh;
                imm8     <= b8;
                writeReg <= we;
        endtask

        task automatic loadWord(input regId_t r, input word_t value);
                issue(OP_LLB, r, r, 4'd0, 4'd0, value[7:0], 1'b1);
                issue(OP_LHB, r, r, 4'd0, 4'd0, value[15:8], 1'b1);
        endtask

        task automatic readViaXor(input regId_t r);
                issue(OP_XOR, 4'd0, r, 4'd0, 4'd0, 8'd0, 1'b0);  // r ^ r0
        endtask

        initial begin
                logic [31:0] rnd;
                aluOp_t      f;
                regId_t      d;
                rstN     = 1'b0;
                op       = OP_XOR;
                dstReg   = 4'd0;
                srcReg1  = 4'd0;
                srcReg2  = 4'd0;
                shamt    = 4'd0;
                imm8     = 8'd0;
                writeReg = 1'b0;
                repeat (resetCycles) @(posedge clk);
                rstN <= 1'b1;

                for (int r = 0; r < numRegs; r++) readViaXor(regId_t'(r));

                // full words built from two byte loads
                for (int r = 1; r < numRegs; r++) begin
                        rnd = nextRandom();
                        loadWord(regId_t'(r), rnd[15:0]);
                        readViaXor(regId_t'(r));
                end

                // r0 ignores writes
                loadWord(4'd0, 16'ha5c3);
                issue(OP_ADD, 4'd0, 4'd1, 4'd2, 4'd0, 8'd0, 1'b1);
                readViaXor(4'd0);

                // ~~~~~~~~~~~~~~~~~~~~
                // saturation
                // ~~~~~~~~~~~~~~~~~~~~
                loadWord(4'd1, 16'h7fff);
                loadWord(4'd2, 16'h0001);
                loadWord(4'd3, 16'h8000);
                loadWord(4'd4, 16'hffff);
                issue(OP_ADD, 4'd9, 4'd2, 4'd4, 4'd0, 8'd0, 1'b1);   // zero, no ovf
                issue(OP_SUB, 4'd10, 4'd2, 4'd1, 4'd0, 8'd0, 1'b1);  // negative, no ovf
                issue(OP_ADD, 4'd5, 4'd1, 4'd2, 4'd0, 8'd0, 1'b1);   // positive clamp
                issue(OP_ADD, 4'd6, 4'd3, 4'd4, 4'd0, 8'd0, 1'b1);   // negative clamp
                issue(OP_SUB, 4'd7, 4'd3, 4'd2, 4'd0, 8'd0, 1'b1);
                issue(OP_SUB, 4'd8, 4'd1, 4'd4, 4'd0, 8'd0, 1'b1);   // leaves v set for shifts
                for (int r = 5; r <= 10; r++) readViaXor(regId_t'(r));

                for (int i = 0; i < numShifts; i++) begin
                        rnd = nextRandom();
                        case (rnd[1:0])
                                2'd0: f = OP_SRA;
                                2'd1: f = OP_ROR;
                                default: f = OP_SLL;
                        endcase
                        issue(f, rnd[7:4], rnd[11:8], rnd[15:12], rnd[19:16], 8'd0, rnd[20]);
                end

                // ~~~~~~~~~~~~~~~~~~~~
                // random mix
                // ~~~~~~~~~~~~~~~~~~~~
                for (int i = 0; i < numRandom; i++) begin
                        rnd = nextRandom();
                        f   = aluOp_t'(rnd[2:0]);
                        d   = rnd[7:4];
                        issue(f, d, (f == OP_LLB || f == OP_LHB) ? d : rnd[11:8],
                              rnd[15:12], rnd[19:16], rnd[27:20], rnd[29:28] != 2'd0);
                end

                @(posedge clk);
                @(negedge clk);  // flags of the last instruction sampled here
                @(posedge clk);
                $display("Test OK");
                $finish;
        end

        initial begin
                #((plannedCycles + margin) * period);
                $display("timeout: stimulus did not finish in the expected number of cycles");
                abortRun();
        end

endmodule

`default_nettype wire

//--- build.f
cpuPkg.sv
register.sv
regFile.sv
alu.sv
flagReg.sv
execCore.sv
execCoreTb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Mdir obj_dir --top-module execCoreTb -f build.f
	@out=$$(./obj_dir/VexecCoreTb); echo "$$out"; echo "$$out" | grep -q "Test OK"

clean:
	rm -rf obj_dir
